//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_wb_commit
RTL_TOP    ?= wb_commit_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
wb_pkg.sv
wb_excp_encode.sv
wb_stage.sv
wb_regfile.sv
wb_excp_csr.sv
wb_commit_top.sv
tb_clk_gen.sv
tb_wb_commit.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int half_period = 20,
    parameter int rst_cycles  = 2
) (
    output logic clk,
    output logic arst_n
);

    // free running, 40 ns period by default
    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

    // release just after an edge, away from the sampling point
    initial begin
        arst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_wb_commit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_commit;
    import wb_pkg::*;

    // cycles per test at one item per cycle
    localparam int n_commit = 200;
    localparam int n_excp   = 120;
    localparam int n_stall  = 40;
    localparam int n_ertn   = 60;
    localparam int n_tlb    = 120;
    localparam int n_bp     = 60;
    localparam int total_cycles = 4 + n_commit + n_excp + n_stall + n_ertn + n_tlb + n_bp;
    localparam int cycle_limit  = total_cycles * 3 / 2;

    logic        clk;
    logic        arst_n;
    logic        left_valid;
    logic        right_ready;
    logic        icache_busy;
    wb_ctrl_t    mem_ctrl;
    wb_excp_t    mem_excp;
    logic [31:0] eentry;
    logic [31:0] tlbrentry;
    logic [4:0]  raddr_a;
    logic [4:0]  raddr_b;
    logic        right_valid;
    logic        left_ready;
    logic        stall;
    logic        excp_flush;
    logic        ertn_flush;
    excp_info_t  excp_info;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic        llbit_set_en;
    logic        llbit_val;
    tlb_req_t    tlb_req;
    logic        tlb_hazard;
    wb_bypass_t  bypass;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    crmd_t       crmd;
    crmd_t       prmd;
    logic [31:0] era;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] badv;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // reference state
    logic [31:0] m_regs [0:31];
    crmd_t       m_crmd;
    crmd_t       m_prmd;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;

    integer seed;
    int     cycles;
    int     test_checks;
    int     test_errors;
    int     all_checks;
    int     all_errors;

    tb_clk_gen #(
        .half_period (20),
        .rst_cycles  (2)
    ) u_tb_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    wb_commit_top #(
        .tlb_idx_w (5)
    ) u_wb_commit_top (
        .clk (clk), .arst_n (arst_n),
        .left_valid (left_valid), .right_ready (right_ready), .icache_busy (icache_busy),
        .mem_ctrl (mem_ctrl), .mem_excp (mem_excp),
        .eentry (eentry), .tlbrentry (tlbrentry), .raddr_a (raddr_a), .raddr_b (raddr_b),
        .right_valid (right_valid), .left_ready (left_ready), .stall (stall),
        .excp_flush (excp_flush), .ertn_flush (ertn_flush), .excp_info (excp_info),
        .rf_we (rf_we), .rf_waddr (rf_waddr), .rf_wdata (rf_wdata),
        .llbit_set_en (llbit_set_en), .llbit_val (llbit_val),
        .tlb_req (tlb_req), .tlb_hazard (tlb_hazard), .bypass (bypass),
        .rdata_a (rdata_a), .rdata_b (rdata_b), .crmd (crmd), .prmd (prmd), .era (era),
        .estat_ecode (estat_ecode), .estat_esubcode (estat_esubcode), .badv (badv),
        .redirect_valid (redirect_valid), .redirect_pc (redirect_pc)
    );

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    // the lowest set cause picks the architectural code
    function automatic excp_info_t expect_info(input logic [15:0] num, input logic [31:0] pc,
                                              input logic [31:0] addr, input logic lv);
        excp_info_t e;
        int         k;
        logic       fetch;
        logic       data;
        e = '0;
        k = -1;
        for (int i = 0; i < 16; i++) begin
            if (k < 0 && num[i]) begin
                k = i;
            end
        end
        case (k)
            1, 10:   e.ecode = ECODE_ADE;
            2, 11:   e.ecode = ECODE_TLBR;
            3:       e.ecode = ECODE_PIF;
            4, 13:   e.ecode = ECODE_PPI;
            5:       e.ecode = ECODE_SYS;
            6:       e.ecode = ECODE_BRK;
            7:       e.ecode = ECODE_INE;
            8:       e.ecode = ECODE_IPE;
            9:       e.ecode = ECODE_ALE;
            12:      e.ecode = ECODE_PME;
            14:      e.ecode = ECODE_PIS;
            15:      e.ecode = ECODE_PIL;
            default: e.ecode = ECODE_INT;
        endcase
        e.esubcode = (k == 10) ? ESUBCODE_ADEM : ESUBCODE_ADEF;
        fetch = (k >= 1 && k <= 4);
        data  = (k >= 9);
        e.badv       = fetch ? pc : addr;
        e.badv_valid = (fetch || data) && lv;
        e.tlb        = ((k >= 2 && k <= 4) || k >= 11) && lv;
        e.refill     = (k == 2 || k == 11) && lv;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("ERROR %0t ns %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // every combinational output against the gating rules
    task automatic check_outputs;
        excp_info_t  e;
        logic        hold;
        logic        live;
        logic        exp_xf;
        logic        exp_ef;
        logic [31:0] exp_pc;
        hold   = left_valid && icache_busy && (mem_excp.excp || mem_excp.ertn);
        live   = left_valid && !mem_excp.excp;
        exp_xf = mem_excp.excp && left_valid && !icache_busy;
        exp_ef = mem_excp.ertn && left_valid && !icache_busy && !mem_excp.excp;
        e = expect_info(mem_excp.excp_num, mem_ctrl.pc, mem_ctrl.mem_addr, left_valid);
        check_value("stall", stall, hold);
        check_value("right_valid", right_valid, left_valid && !hold);
        check_value("left_ready", left_ready, right_ready && !hold);
        check_value("excp_flush", excp_flush, exp_xf);
        check_value("ertn_flush", ertn_flush, exp_ef);
        check_value("excp_info.ecode", excp_info.ecode, e.ecode);
        check_value("excp_info.esubcode", excp_info.esubcode, e.esubcode);
        check_value("excp_info.badv_valid", excp_info.badv_valid, e.badv_valid);
        check_value("excp_info.tlb", excp_info.tlb, e.tlb);
        check_value("excp_info.refill", excp_info.refill, e.refill);
        if (e.badv_valid) begin
            check_value("excp_info.badv", excp_info.badv, e.badv);
        end
        check_value("rf_we", rf_we, mem_ctrl.wreg_en && mem_ctrl.inst_valid && live);
        check_value("rf_waddr", rf_waddr, mem_ctrl.wreg_idx);
        check_value("rf_wdata", rf_wdata, mem_ctrl.result);
        check_value("llbit_set_en", llbit_set_en, mem_ctrl.llbit_set && live);
        check_value("llbit_val", llbit_val, mem_ctrl.llbit_val);
        // op bits from bit 0 up are inv wr rd fill srch
        check_value("tlb_req.inv_en", tlb_req.inv_en, mem_ctrl.tlb_op[0] && live);
        check_value("tlb_req.wr_en", tlb_req.wr_en, mem_ctrl.tlb_op[1] && live);
        check_value("tlb_req.rd_en", tlb_req.rd_en, mem_ctrl.tlb_op[2] && left_valid);
        check_value("tlb_req.fill_en", tlb_req.fill_en, mem_ctrl.tlb_op[3] && live);
        check_value("tlb_req.srch_en", tlb_req.srch_en, mem_ctrl.tlb_op[4] && left_valid);
        check_value("tlb_req.inv_op", tlb_req.inv_op, mem_ctrl.inv_op);
        check_value("tlb_req.inv_asid", tlb_req.inv_asid, mem_ctrl.inv_asid);
        check_value("tlb_req.inv_vpn", tlb_req.inv_vpn, mem_ctrl.inv_vpn);
        check_value("tlb_req.tlb_idx", tlb_req.tlb_idx, mem_ctrl.tlb_idx);
        check_value("tlb_req.tlb_found", tlb_req.tlb_found, mem_ctrl.tlb_found);
        check_value("tlb_hazard", tlb_hazard,
                    (mem_ctrl.tlb_op[2] || mem_ctrl.tlb_op[4]) && live);
        // forwarding is live only with a valid slot
        check_value("bypass.result", bypass.result, mem_ctrl.result);
        check_value("bypass.wreg_idx", bypass.wreg_idx, mem_ctrl.wreg_idx);
        check_value("bypass.wreg_en", bypass.wreg_en, mem_ctrl.wreg_en && left_valid);
        check_value("redirect_valid", redirect_valid, exp_xf || exp_ef);
        exp_pc = exp_xf ? (e.refill ? tlbrentry : eentry) : m_era;
        if (exp_xf || exp_ef) begin
            check_value("redirect_pc", redirect_pc, exp_pc);
        end
    endtask

    // registered state as left by the previous edge
    task automatic check_state;
        check_value("crmd", crmd, m_crmd);
        check_value("prmd", prmd, m_prmd);
        check_value("era", era, m_era);
        check_value("estat_ecode", estat_ecode, m_ecode);
        check_value("estat_esubcode", estat_esubcode, m_esub);
        check_value("badv", badv, m_badv);
        check_value("rdata_a", rdata_a, m_regs[raddr_a]);
        check_value("rdata_b", rdata_b, m_regs[raddr_b]);
    endtask

    // what the coming edge should do
    task automatic update_model;
        excp_info_t e;
        e = expect_info(mem_excp.excp_num, mem_ctrl.pc, mem_ctrl.mem_addr, left_valid);
        if (left_valid && !icache_busy && mem_excp.excp) begin
            m_prmd  = m_crmd;
            m_crmd  = '0;
            m_era   = mem_ctrl.pc;
            m_ecode = e.ecode;
            m_esub  = e.esubcode;
            if (e.badv_valid) begin
                m_badv = e.badv;
            end
        end else if (left_valid && !icache_busy && mem_excp.ertn) begin
            m_crmd = m_prmd;
        end
        if (left_valid && !mem_excp.excp && mem_ctrl.wreg_en && mem_ctrl.inst_valid
            && mem_ctrl.wreg_idx != 5'd0) begin
            m_regs[mem_ctrl.wreg_idx] = mem_ctrl.result;
        end
    endtask

    // check mid-cycle and move 2 ns past the next edge
    task automatic run_cycle;
        #1;
        check_outputs();
        check_state();
        update_model();
        @(posedge clk);
        #2;
    endtask

    task automatic randomize_item;
        logic [191:0] bits;
        logic [31:0]  r;
        bits = {next_random(), next_random(), next_random(),
                next_random(), next_random(), next_random()};
        r = next_random();
        mem_ctrl          = bits[$bits(wb_ctrl_t)-1:0];
        mem_excp.excp_num = r[15:0];
        mem_excp.excp     = r[16];
        mem_excp.ertn     = r[17];
        right_ready       = r[18];
        raddr_a           = r[23:19];
        raddr_b           = r[28:24];
        left_valid        = r[29];
        icache_busy       = r[30];
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        all_checks += test_checks;
        all_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        logic [4:0]  last_waddr;
        logic [31:0] r;
        seed        = 32'h4416_69fa;
        cycles      = 0;
        test_checks = 0;
        test_errors = 0;
        all_checks  = 0;
        all_errors  = 0;
        last_waddr  = 5'd0;
        left_valid  = 1'b0;
        right_ready = 1'b1;
        icache_busy = 1'b0;
        mem_ctrl    = '0;
        mem_excp    = '0;
        eentry      = 32'h1c00_8000;
        tlbrentry   = 32'h1c00_f000;
        raddr_a     = 5'd0;
        raddr_b     = 5'd0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        m_crmd  = '0;
        m_prmd  = '0;
        m_era   = '0;
        m_badv  = '0;
        m_ecode = '0;
        m_esub  = '0;
        wait (arst_n);
        @(posedge clk);
        #2;

        // plain commits with the last target read back on port a
        for (int n = 0; n < n_commit; n++) begin
            randomize_item();
            left_valid    = 1'b1;
            icache_busy   = 1'b0;
            mem_excp.excp = 1'b0;
            mem_excp.ertn = 1'b0;
            raddr_a       = last_waddr;
            last_waddr    = mem_ctrl.wreg_idx;
            run_cycle();
        end
        end_test("random commits");

        // sparse cause vectors so every priority level shows up
        for (int n = 0; n < n_excp; n++) begin
            randomize_item();
            r = next_random();
            left_valid        = 1'b1;
            icache_busy       = 1'b0;
            mem_excp.excp     = 1'b1;
            mem_excp.excp_num = mem_excp.excp_num & r[15:0] & r[31:16];
            if (mem_excp.excp_num == 16'd0) begin
                mem_excp.excp_num = 16'd1 << r[3:0];
            end
            run_cycle();
        end
        end_test("exception priority");

        // redirect held off while the icache works
        for (int n = 0; n < n_stall; n++) begin
            randomize_item();
            r = next_random();
            left_valid    = 1'b1;
            icache_busy   = 1'b1;
            mem_excp.excp = r[0];
            mem_excp.ertn = !r[0] || r[1];
            run_cycle();
        end
        end_test("icache stall");

        // mostly clean returns with a few colliding exceptions
        for (int n = 0; n < n_ertn; n++) begin
            randomize_item();
            r = next_random();
            left_valid    = 1'b1;
            icache_busy   = 1'b0;
            mem_excp.ertn = 1'b1;
            mem_excp.excp = (r[2:0] == 3'd0);
            run_cycle();
        end
        end_test("exception return");

        // fully random slot with strobes checked each cycle
        for (int n = 0; n < n_tlb; n++) begin
            randomize_item();
            r = next_random();
            icache_busy = r[0] && r[1];
            run_cycle();
        end
        end_test("tlb and llbit gating");

        for (int n = 0; n < n_bp; n++) begin
            randomize_item();
            r = next_random();
            mem_excp.excp = r[0] && r[1];
            mem_excp.ertn = r[2] && r[3];
            run_cycle();
        end
        end_test("back-pressure");

        $display("total: %0d checks, %0d errors", all_checks, all_errors);
        if (all_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- wb_commit_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_commit_top #(
    parameter int tlb_idx_w = 5
) (
    input  wire logic             clk,
    input  wire logic             arst_n,
    input  wire logic             left_valid,
    input  wire logic             right_ready,
    input  wire logic             icache_busy,
    input  wire wb_pkg::wb_ctrl_t mem_ctrl,
    input  wire wb_pkg::wb_excp_t mem_excp,
    input  wire logic [31:0]      eentry,
    input  wire logic [31:0]      tlbrentry,
    input  wire logic [4:0]       raddr_a,
    input  wire logic [4:0]       raddr_b,
    output logic                  right_valid,
    output logic                  left_ready,
    output logic                  stall,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output wb_pkg::excp_info_t    excp_info,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata,
    output logic                  llbit_set_en,
    output logic                  llbit_val,
    output wb_pkg::tlb_req_t      tlb_req,
    output logic                  tlb_hazard,
    output wb_pkg::wb_bypass_t    bypass,
    output logic [31:0]           rdata_a,
    output logic [31:0]           rdata_b,
    output wb_pkg::crmd_t         crmd,
    output wb_pkg::crmd_t         prmd,
    output logic [31:0]           era,
    output logic [5:0]            estat_ecode,
    output logic [8:0]            estat_esubcode,
    output logic [31:0]           badv,
    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc
);

    // commit gating, all combinational
    wb_stage #(
        .tlb_idx_w (tlb_idx_w)
    ) u_wb_stage (
        .left_valid   (left_valid),
        .right_ready  (right_ready),
        .icache_busy  (icache_busy),
        .mem_ctrl     (mem_ctrl),
        .mem_excp     (mem_excp),
        .right_valid  (right_valid),
        .left_ready   (left_ready),
        .stall        (stall),
        .excp_flush   (excp_flush),
        .ertn_flush   (ertn_flush),
        .excp_info    (excp_info),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .llbit_set_en (llbit_set_en),
        .llbit_val    (llbit_val),
        .tlb_req      (tlb_req),
        .tlb_hazard   (tlb_hazard),
        .bypass       (bypass)
    );

    wb_regfile u_wb_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    // era takes the pc of the slot in writeback
    wb_excp_csr u_wb_excp_csr (
        .clk            (clk),
        .arst_n         (arst_n),
        .excp_flush     (excp_flush),
        .ertn_flush     (ertn_flush),
        .pc             (mem_ctrl.pc),
        .excp_info      (excp_info),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .crmd           (crmd),
        .prmd           (prmd),
        .era            (era),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .badv           (badv),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

//--- wb_excp_csr.sv
`timescale 1ns/1ps
`default_nettype none

module wb_excp_csr (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               excp_flush,
    input  wire logic               ertn_flush,
    input  wire logic [31:0]        pc,
    input  wire wb_pkg::excp_info_t excp_info,
    input  wire logic [31:0]        eentry,
    input  wire logic [31:0]        tlbrentry,
    output wb_pkg::crmd_t           crmd,
    output wb_pkg::crmd_t           prmd,
    output logic [31:0]             era,
    output logic [5:0]              estat_ecode,
    output logic [8:0]              estat_esubcode,
    output logic [31:0]             badv,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd           <= '0;
            prmd           <= '0;
            era            <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            badv           <= '0;
        end else if (excp_flush) begin
            // park the current mode and enter kernel with irqs off
            prmd           <= crmd;
            crmd           <= '0;
            era            <= pc;
            estat_ecode    <= excp_info.ecode;
            estat_esubcode <= excp_info.esubcode;
            // badv only for address-carrying causes
            if (excp_info.badv_valid) begin
                badv <= excp_info.badv;
            end
        end else if (ertn_flush) begin
            crmd <= prmd;
        end
    end

    // redirect target for fetch
    always_comb begin
        redirect_valid = excp_flush || ertn_flush;
        if (excp_flush) begin
            // refill has its own entry point
            redirect_pc = excp_info.refill ? tlbrentry : eentry;
        end else begin
            redirect_pc = era;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(excp_flush && ertn_flush))
        else $error("wb_excp_csr: exception and ertn flush together");

endmodule

`default_nettype wire

//--- wb_excp_encode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_excp_encode (
    input  wire logic [15:0]   excp_num,
    input  wire logic [31:0]   pc,
    input  wire logic [31:0]   mem_addr,
    input  wire logic          left_valid,
    output wb_pkg::excp_info_t info
);
    import wb_pkg::*;

    logic [3:0] sel;
    logic       any;
    logic       fetch_fault;
    logic       data_fault;
    logic       tlb_fault;
    logic       refill_fault;

    // scan downward so the lowest set bit lands last
    always_comb begin
        sel = 4'd0;
        any = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            if (excp_num[i]) begin
                sel = 4'(i);
                any = 1'b1;
            end
        end
    end

    // classes of the winning cause
    always_comb begin
        fetch_fault  = any && (sel inside {[4'd1:4'd4]});
        data_fault   = any && (sel >= 4'd9);
        tlb_fault    = any && (sel inside {[4'd2:4'd4], [4'd11:4'd15]});
        refill_fault = any && (sel == 4'd2 || sel == 4'd11);
    end

    always_comb begin
        info = '0;
        if (any) begin
            case (sel)
                4'd0:    info.ecode = ECODE_INT;
                4'd1:    info.ecode = ECODE_ADE;
                4'd2:    info.ecode = ECODE_TLBR;
                4'd3:    info.ecode = ECODE_PIF;
                4'd4:    info.ecode = ECODE_PPI;
                4'd5:    info.ecode = ECODE_SYS;
                4'd6:    info.ecode = ECODE_BRK;
                4'd7:    info.ecode = ECODE_INE;
                4'd8:    info.ecode = ECODE_IPE;
                4'd9:    info.ecode = ECODE_ALE;
                4'd10:   info.ecode = ECODE_ADE;
                4'd11:   info.ecode = ECODE_TLBR;
                4'd12:   info.ecode = ECODE_PME;
                4'd13:   info.ecode = ECODE_PPI;
                4'd14:   info.ecode = ECODE_PIS;
                default: info.ecode = ECODE_PIL;
            endcase
        end
        // only adem takes a nonzero sub-code
        info.esubcode = (any && sel == 4'd10) ? ESUBCODE_ADEM : ESUBCODE_ADEF;
        // fetch faults report pc and data faults the access address
        if (fetch_fault) begin
            info.badv = pc;
        end else if (data_fault) begin
            info.badv = mem_addr;
        end
        info.badv_valid = (fetch_fault || data_fault) && left_valid;
        info.tlb        = tlb_fault && left_valid;
        info.refill     = refill_fault && left_valid;
    end

endmodule

`default_nettype wire

//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

    // exception codes
    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_IPE  = 6'h0e;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    // ade sub-codes, fetch vs data side
    localparam logic [8:0] ESUBCODE_ADEF = 9'd0;
    localparam logic [8:0] ESUBCODE_ADEM = 9'd1;

    // bit positions inside tlb_op
    localparam int TLB_OP_INV  = 0;
    localparam int TLB_OP_WR   = 1;
    localparam int TLB_OP_RD   = 2;
    localparam int TLB_OP_FILL = 3;
    localparam int TLB_OP_SRCH = 4;

    // control word from the memory stage
    typedef struct packed {
        logic        llbit_val;
        logic        llbit_set;
        logic [4:0]  tlb_idx;
        logic        tlb_found;
        logic [4:0]  tlb_op;
        logic [4:0]  inv_op;
        logic [9:0]  inv_asid;
        logic [18:0] inv_vpn;
        logic [31:0] mem_addr;
        logic        inst_valid;
        logic [4:0]  wreg_idx;
        logic        wreg_en;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] result;
    } wb_ctrl_t;

    // exception word, excp_num bit 0 is the interrupt
    typedef struct packed {
        logic        ertn;
        logic [15:0] excp_num;
        logic        excp;
    } wb_excp_t;

    typedef struct packed {
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic        badv_valid;
        logic        tlb;
        logic        refill;
    } excp_info_t;

    // forwarding back into decode
    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  wreg_idx;
        logic        wreg_en;
    } wb_bypass_t;

    typedef struct packed {
        logic        inv_en;
        logic        wr_en;
        logic        rd_en;
        logic        fill_en;
        logic        srch_en;
        logic [4:0]  inv_op;
        logic [9:0]  inv_asid;
        logic [18:0] inv_vpn;
        logic [4:0]  tlb_idx;
        logic        tlb_found;
    } tlb_req_t;

    // laid out as in the register, ie above plv
    typedef struct packed {
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

endpackage

`default_nettype wire

//--- wb_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regfile (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        we,
    input  wire logic [4:0]  waddr,
    input  wire logic [31:0] wdata,
    input  wire logic [4:0]  raddr_a,
    input  wire logic [4:0]  raddr_b,
    output logic [31:0]      rdata_a,
    output logic [31:0]      rdata_b
);

    // r0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, new value shows a cycle later
    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

`default_nettype wire

//--- wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage #(
    parameter int tlb_idx_w = 5
) (
    input  wire logic             left_valid,
    input  wire logic             right_ready,
    input  wire logic             icache_busy,
    input  wire wb_pkg::wb_ctrl_t mem_ctrl,
    input  wire wb_pkg::wb_excp_t mem_excp,
    output logic                  right_valid,
    output logic                  left_ready,
    output logic                  stall,
    output logic                  excp_flush,
    output logic                  ertn_flush,
    output wb_pkg::excp_info_t    excp_info,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [31:0]           rf_wdata,
    output logic                  llbit_set_en,
    output logic                  llbit_val,
    output wb_pkg::tlb_req_t      tlb_req,
    output logic                  tlb_hazard,
    output wb_pkg::wb_bypass_t    bypass
);
    import wb_pkg::*;

    logic                 excp;
    logic                 ertn;
    logic                 hold;
    logic                 commit_ok;
    logic [tlb_idx_w-1:0] tlb_idx;

    assign excp = mem_excp.excp;
    assign ertn = mem_excp.ertn;

    // index trimmed to the configured tlb depth
    assign tlb_idx = mem_ctrl.tlb_idx[tlb_idx_w-1:0];

    wb_excp_encode u_wb_excp_encode (
        .excp_num   (mem_excp.excp_num),
        .pc         (mem_ctrl.pc),
        .mem_addr   (mem_ctrl.mem_addr),
        .left_valid (left_valid),
        .info       (excp_info)
    );

    // redirect must wait until the icache is idle
    assign hold  = left_valid && icache_busy && (excp || ertn);
    assign stall = hold;

    assign right_valid = left_valid && !hold;
    assign left_ready  = right_ready && !hold;

    assign excp_flush = excp && left_valid && !icache_busy;
    // exception outranks a return in the same slot
    assign ertn_flush = ertn && left_valid && !icache_busy && !excp;

    // side effects that a faulting instruction may not have
    assign commit_ok = left_valid && !excp;

    assign rf_we    = mem_ctrl.wreg_en && mem_ctrl.inst_valid && commit_ok;
    assign rf_waddr = mem_ctrl.wreg_idx;
    assign rf_wdata = mem_ctrl.result;

    assign llbit_set_en = mem_ctrl.llbit_set && commit_ok;
    assign llbit_val    = mem_ctrl.llbit_val;

    always_comb begin
        tlb_req.inv_en    = mem_ctrl.tlb_op[TLB_OP_INV] && commit_ok;
        tlb_req.wr_en     = mem_ctrl.tlb_op[TLB_OP_WR] && commit_ok;
        tlb_req.fill_en   = mem_ctrl.tlb_op[TLB_OP_FILL] && commit_ok;
        // read and search only need a live slot
        tlb_req.rd_en     = mem_ctrl.tlb_op[TLB_OP_RD] && left_valid;
        tlb_req.srch_en   = mem_ctrl.tlb_op[TLB_OP_SRCH] && left_valid;
        tlb_req.inv_op    = mem_ctrl.inv_op;
        tlb_req.inv_asid  = mem_ctrl.inv_asid;
        tlb_req.inv_vpn   = mem_ctrl.inv_vpn;
        tlb_req.tlb_idx   = 5'(tlb_idx);
        tlb_req.tlb_found = mem_ctrl.tlb_found;
    end

    // tlbrd and tlbsrch update csrs that younger ops may read
    assign tlb_hazard = (mem_ctrl.tlb_op[TLB_OP_RD] || mem_ctrl.tlb_op[TLB_OP_SRCH])
                        && commit_ok;

    // forwarding sees any live slot
    always_comb begin
        bypass.result   = mem_ctrl.result;
        bypass.wreg_idx = mem_ctrl.wreg_idx;
        bypass.wreg_en  = mem_ctrl.wreg_en && left_valid;
    end

endmodule

`default_nettype wire
